// File: cpu_pkg.sv
//////////////////////////////
// CPU shared definitions
// ALU operation codes, operand source selects
// and default datapath sizes
//////////////////////////////

package cpu_pkg;

	// Default datapath width and register count
	localparam int DATA_W_DEF  = 32;
	localparam int REG_CNT_DEF = 16;

	// ALU functions
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4,
		ALU_SLL = 3'd5,
		ALU_SRL = 3'd6,
		ALU_SLT = 3'd7
	} alu_op_t;

	// Operand source, immediate only valid for operand B
	typedef enum logic [1:0] {
		SEL_RF  = 2'd0,
		SEL_IMM = 2'd1,
		SEL_EX  = 2'd2,
		SEL_WB  = 2'd3
	} operand_sel_t;

endpackage

// File: fwd_if.sv
//////////////////////////////
// Forwarding bus
// Results held in EX and WB with their
// destination registers
//////////////////////////////

`timescale 1ns/10ps

interface fwd_if #(
	parameter int DATA_W  = cpu_pkg::DATA_W_DEF,
	parameter int REG_CNT = cpu_pkg::REG_CNT_DEF
);
	localparam int REG_W = $clog2(REG_CNT);

	// EX stage result, combinational ALU output
	logic              ex_valid;
	logic [REG_W-1:0]  ex_rd;
	logic [DATA_W-1:0] ex_data;

	// WB stage result, straight from the writeback register
	logic              wb_valid;
	logic [REG_W-1:0]  wb_rd;
	logic [DATA_W-1:0] wb_data;

	// Driven by the execute unit
	modport src (output ex_valid, ex_rd, ex_data, wb_valid, wb_rd, wb_data);

	// Read by hazard detection and the operand muxes
	modport sink (input ex_valid, ex_rd, ex_data, wb_valid, wb_rd, wb_data);

endinterface

// File: pipe_stage.sv
//////////////////////////////
// Pipeline register stage
// One-entry valid/ready register
// for an arbitrary payload type
//////////////////////////////

`timescale 1ns/10ps

module pipe_stage #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     in_valid,
	output logic     in_ready,
	input  payload_t in_data,
	output logic     out_valid,
	input  logic     out_ready,
	output payload_t out_data
);

	// Free when empty or when the held entry leaves this cycle
	assign in_ready = !out_valid || out_ready;

	// Occupancy flag
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else if (in_ready) begin
			out_valid <= in_valid;
		end
	end

	// Payload only captured on a real transfer
	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			out_data <= in_data;
		end
	end

endmodule

// File: reg_file.sv
//////////////////////////////
// Integer register file
// Two async read ports, one write port
// Register 0 hardwired to zero
//////////////////////////////

`timescale 1ns/10ps

module reg_file #(
	parameter int DATA_W  = cpu_pkg::DATA_W_DEF,
	parameter int REG_CNT = cpu_pkg::REG_CNT_DEF,
	localparam int REG_W  = $clog2(REG_CNT)
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic [REG_W-1:0]  ra,
	input  logic [REG_W-1:0]  rb,
	output logic [DATA_W-1:0] rd_data_a,
	output logic [DATA_W-1:0] rd_data_b,
	input  logic              wr_en,
	input  logic [REG_W-1:0]  wr_addr,
	input  logic [DATA_W-1:0] wr_data
);

	logic [DATA_W-1:0] regs [REG_CNT];

	// Write port, index 0 dropped
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < REG_CNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && (wr_addr != '0)) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Read ports
	assign rd_data_a = (ra == '0) ? '0 : regs[ra];
	assign rd_data_b = (rb == '0) ? '0 : regs[rb];

endmodule

// File: decode_ctrl.sv
//////////////////////////////
// Hazard detection
// Matches source registers against EX and WB
// destinations and picks each operand source
//////////////////////////////

`timescale 1ns/10ps

module decode_ctrl #(
	parameter int REG_CNT = cpu_pkg::REG_CNT_DEF,
	localparam int REG_W  = $clog2(REG_CNT)
) (
	input  logic                   [REG_W-1:0] ra,
	input  logic                   [REG_W-1:0] rb,
	input  logic                               use_imm,
	fwd_if.sink                                fwd,
	output cpu_pkg::operand_sel_t              sel_a,
	output cpu_pkg::operand_sel_t              sel_b
);

	import cpu_pkg::*;

	//////////////////////////////
	// Forwarding priority
	//////////////////////////////

	// Youngest producer wins, EX before WB
	// Register 0 is constant so it never takes a forward
	function automatic operand_sel_t pick_src(
		input logic [REG_W-1:0] src,
		input logic             ex_valid,
		input logic [REG_W-1:0] ex_rd,
		input logic             wb_valid,
		input logic [REG_W-1:0] wb_rd
	);
		if (src == '0) begin
			return SEL_RF;
		end else if (ex_valid && (ex_rd == src)) begin
			return SEL_EX;
		end else if (wb_valid && (wb_rd == src)) begin
			return SEL_WB;
		end
		return SEL_RF;
	endfunction

	// Operand A is always a register source
	assign sel_a = pick_src(ra, fwd.ex_valid, fwd.ex_rd, fwd.wb_valid, fwd.wb_rd);

	// Immediate overrides any hazard on B
	assign sel_b = use_imm ? SEL_IMM :
		pick_src(rb, fwd.ex_valid, fwd.ex_rd, fwd.wb_valid, fwd.wb_rd);

endmodule

// File: operand_mux.sv
//////////////////////////////
// Operand muxes
// Forwarding selection and the operand
// registers feeding the EX stage
//////////////////////////////

`timescale 1ns/10ps

module operand_mux #(
	parameter int DATA_W = cpu_pkg::DATA_W_DEF
) (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               load,
	input  logic                  [DATA_W-1:0] rf_data_a,
	input  logic                  [DATA_W-1:0] rf_data_b,
	input  logic                  [DATA_W-1:0] imm,
	input  cpu_pkg::operand_sel_t              sel_a,
	input  cpu_pkg::operand_sel_t              sel_b,
	fwd_if.sink                                fwd,
	output logic                  [DATA_W-1:0] operand_a,
	output logic                  [DATA_W-1:0] operand_b
);

	import cpu_pkg::*;

	logic [DATA_W-1:0] muxed_a;
	logic [DATA_W-1:0] muxed_b;

	// Four-way source select, shared by both operands
	function automatic logic [DATA_W-1:0] pick_operand(
		input operand_sel_t      sel,
		input logic [DATA_W-1:0] rf_val,
		input logic [DATA_W-1:0] imm_val,
		input logic [DATA_W-1:0] ex_val,
		input logic [DATA_W-1:0] wb_val
	);
		case (sel)
			SEL_IMM: return imm_val;
			SEL_EX:  return ex_val;
			SEL_WB:  return wb_val;
			default: return rf_val;
		endcase
	endfunction

	// Decode never asks for the immediate on A
	assign muxed_a = pick_operand(sel_a, rf_data_a, imm, fwd.ex_data, fwd.wb_data);
	assign muxed_b = pick_operand(sel_b, rf_data_b, imm, fwd.ex_data, fwd.wb_data);

	//////////////////////////////
	// Operand registers
	//////////////////////////////

	// Load follows EX acceptance, bubbles load too
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			operand_a <= '0;
			operand_b <= '0;
		end else if (load) begin
			operand_a <= muxed_a;
			operand_b <= muxed_b;
		end
	end

endmodule

// File: exec_unit.sv
//////////////////////////////
// Execute unit
// EX control stage, eight-function ALU,
// writeback stage and result stream
// Drives the forwarding bus and the
// register file write port
//////////////////////////////

`timescale 1ns/10ps

module exec_unit #(
	parameter int DATA_W  = cpu_pkg::DATA_W_DEF,
	parameter int REG_CNT = cpu_pkg::REG_CNT_DEF,
	localparam int REG_W  = $clog2(REG_CNT)
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          in_valid,
	output logic                          in_ready,
	input  cpu_pkg::alu_op_t              in_op,
	input  logic             [REG_W-1:0]  in_rd,
	input  logic             [DATA_W-1:0] operand_a,
	input  logic             [DATA_W-1:0] operand_b,
	fwd_if.src                            fwd,
	output logic                          out_valid,
	input  logic                          out_ready,
	output logic             [REG_W-1:0]  out_rd,
	output logic             [DATA_W-1:0] out_data,
	output logic                          wr_en,
	output logic             [REG_W-1:0]  wr_addr,
	output logic             [DATA_W-1:0] wr_data
);

	import cpu_pkg::*;

	// Shift amount covers the full data width
	localparam int SH_W = $clog2(DATA_W);

	typedef struct packed {
		alu_op_t          op;
		logic [REG_W-1:0] rd;
	} ex_ctl_t;

	typedef struct packed {
		logic [REG_W-1:0]  rd;
		logic [DATA_W-1:0] data;
	} wb_t;

	ex_ctl_t           ex_in;
	ex_ctl_t           ex_ctl;
	logic              ex_valid;
	logic              wb_ready;
	logic [DATA_W-1:0] alu_result;
	wb_t               wb_in;
	wb_t               wb_q;

	//////////////////////////////
	// EX stage
	//////////////////////////////

	assign ex_in = '{op: in_op, rd: in_rd};

	// Operands sit in operand_mux, only control is staged here
	pipe_stage #(.payload_t(ex_ctl_t)) u_ex_stage (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_data   (ex_in),
		.out_valid (ex_valid),
		.out_ready (wb_ready),
		.out_data  (ex_ctl)
	);

	// ALU
	always_comb begin
		case (ex_ctl.op)
			ALU_ADD: alu_result = operand_a + operand_b;
			ALU_SUB: alu_result = operand_a - operand_b;
			ALU_AND: alu_result = operand_a & operand_b;
			ALU_OR:  alu_result = operand_a | operand_b;
			ALU_XOR: alu_result = operand_a ^ operand_b;
			ALU_SLL: alu_result = operand_a << operand_b[SH_W-1:0];
			ALU_SRL: alu_result = operand_a >> operand_b[SH_W-1:0];
			// Signed compare, zero extended flag
			ALU_SLT: alu_result = DATA_W'($signed(operand_a) < $signed(operand_b));
			default: alu_result = '0;
		endcase
	end

	//////////////////////////////
	// WB stage
	//////////////////////////////

	assign wb_in = '{rd: ex_ctl.rd, data: alu_result};

	pipe_stage #(.payload_t(wb_t)) u_wb_stage (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (ex_valid),
		.in_ready  (wb_ready),
		.in_data   (wb_in),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data  (wb_q)
	);

	// Result stream
	assign out_rd   = wb_q.rd;
	assign out_data = wb_q.data;

	// Architectural write on the output handshake, r0 skipped
	assign wr_en   = out_valid && out_ready && (wb_q.rd != '0);
	assign wr_addr = wb_q.rd;
	assign wr_data = wb_q.data;

	// Forwarding sources
	assign fwd.ex_valid = ex_valid;
	assign fwd.ex_rd    = ex_ctl.rd;
	assign fwd.ex_data  = alu_result;
	assign fwd.wb_valid = out_valid;
	assign fwd.wb_rd    = wb_q.rd;
	assign fwd.wb_data  = wb_q.data;

endmodule

// File: int_pipe_top.sv
//////////////////////////////
// Integer execute slice
// Register read, operand forwarding, ALU
// and writeback on valid/ready streams
//////////////////////////////

`timescale 1ns/10ps

module int_pipe_top #(
	parameter int DATA_W  = cpu_pkg::DATA_W_DEF,
	parameter int REG_CNT = cpu_pkg::REG_CNT_DEF,
	localparam int REG_W  = $clog2(REG_CNT)
) (
	input  logic                          clk,
	input  logic                          rst_n,
	// Instruction stream
	input  logic                          in_valid,
	output logic                          in_ready,
	input  cpu_pkg::alu_op_t              in_op,
	input  logic             [REG_W-1:0]  in_rd,
	input  logic             [REG_W-1:0]  in_ra,
	input  logic             [REG_W-1:0]  in_rb,
	input  logic             [DATA_W-1:0] in_imm,
	input  logic                          in_use_imm,
	// Result stream
	output logic                          out_valid,
	input  logic                          out_ready,
	output logic             [REG_W-1:0]  out_rd,
	output logic             [DATA_W-1:0] out_data
);

	import cpu_pkg::*;

	logic [DATA_W-1:0] rf_data_a;
	logic [DATA_W-1:0] rf_data_b;
	operand_sel_t      sel_a;
	operand_sel_t      sel_b;
	logic [DATA_W-1:0] operand_a;
	logic [DATA_W-1:0] operand_b;
	logic              wr_en;
	logic [REG_W-1:0]  wr_addr;
	logic [DATA_W-1:0] wr_data;

	// EX and WB results back to decode
	fwd_if #(.DATA_W(DATA_W), .REG_CNT(REG_CNT)) u_fwd ();

	reg_file #(.DATA_W(DATA_W), .REG_CNT(REG_CNT)) u_reg_file (
		.clk       (clk),
		.rst_n     (rst_n),
		.ra        (in_ra),
		.rb        (in_rb),
		.rd_data_a (rf_data_a),
		.rd_data_b (rf_data_b),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data)
	);

	decode_ctrl #(.REG_CNT(REG_CNT)) u_decode_ctrl (
		.ra      (in_ra),
		.rb      (in_rb),
		.use_imm (in_use_imm),
		.fwd     (u_fwd.sink),
		.sel_a   (sel_a),
		.sel_b   (sel_b)
	);

	// Operands load whenever EX can take a new entry
	operand_mux #(.DATA_W(DATA_W)) u_operand_mux (
		.clk       (clk),
		.rst_n     (rst_n),
		.load      (in_ready),
		.rf_data_a (rf_data_a),
		.rf_data_b (rf_data_b),
		.imm       (in_imm),
		.sel_a     (sel_a),
		.sel_b     (sel_b),
		.fwd       (u_fwd.sink),
		.operand_a (operand_a),
		.operand_b (operand_b)
	);

	exec_unit #(.DATA_W(DATA_W), .REG_CNT(REG_CNT)) u_exec_unit (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_op     (in_op),
		.in_rd     (in_rd),
		.operand_a (operand_a),
		.operand_b (operand_b),
		.fwd       (u_fwd.src),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_rd    (out_rd),
		.out_data  (out_data),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data)
	);

endmodule

// File: int_pipe_assert.sv
//////////////////////////////
// Execute slice assertions
// Forwarding and result stream rules,
// bound into the top level
//////////////////////////////

`timescale 1ns/10ps

module int_pipe_assert #(
	parameter int DATA_W  = cpu_pkg::DATA_W_DEF,
	parameter int REG_CNT = cpu_pkg::REG_CNT_DEF,
	localparam int REG_W  = $clog2(REG_CNT)
) (
	input logic                          clk,
	input logic                          rst_n,
	input logic                          in_ready,
	input logic                          out_valid,
	input logic                          out_ready,
	input logic             [REG_W-1:0]  out_rd,
	input logic             [DATA_W-1:0] out_data,
	input cpu_pkg::operand_sel_t         sel_a,
	input cpu_pkg::operand_sel_t         sel_b,
	input logic             [DATA_W-1:0] operand_a,
	input logic             [DATA_W-1:0] operand_b,
	input logic             [DATA_W-1:0] ex_data
);

	import cpu_pkg::*;

	// Held result must not move under back-pressure
	out_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(out_valid && !out_ready) |=> (out_valid && $stable(out_data) && $stable(out_rd)))
		else $error("result stream changed while stalled");

	a_no_imm: assert property (@(posedge clk) disable iff (!rst_n) sel_a != SEL_IMM)
		else $error("immediate selected for operand A");

	// EX forward captures the ALU output of that same edge
	ex_fwd_a: assert property (@(posedge clk) disable iff (!rst_n)
		(in_ready && sel_a == SEL_EX) |=> (operand_a == $past(ex_data)))
		else $error("operand A differs from forwarded EX data");

	ex_fwd_b: assert property (@(posedge clk) disable iff (!rst_n)
		(in_ready && sel_b == SEL_EX) |=> (operand_b == $past(ex_data)))
		else $error("operand B differs from forwarded EX data");

	ready_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> in_ready)
		else $error("in_ready low in first cycle after reset");

endmodule

bind int_pipe_top int_pipe_assert #(.DATA_W(DATA_W), .REG_CNT(REG_CNT)) u_int_pipe_assert (
	.clk       (clk),
	.rst_n     (rst_n),
	.in_ready  (in_ready),
	.out_valid (out_valid),
	.out_ready (out_ready),
	.out_rd    (out_rd),
	.out_data  (out_data),
	.sel_a     (sel_a),
	.sel_b     (sel_b),
	.operand_a (operand_a),
	.operand_b (operand_b),
	.ex_data   (u_fwd.ex_data)
);

// File: tb_int_pipe.sv
//////////////////////////////
// Execute slice testbench
// Random and directed instruction streams
// checked against an architectural model
//////////////////////////////

`timescale 1ns/10ps

module tb_int_pipe;

	import cpu_pkg::*;

	localparam int DATA_W  = DATA_W_DEF;
	localparam int REG_CNT = REG_CNT_DEF;
	localparam int REG_W   = $clog2(REG_CNT);
	localparam int SH_W    = $clog2(DATA_W);
	localparam int TIMEOUT = 200;

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [REG_W-1:0]  reg_idx_t;

	logic     clk;
	logic     rst_n;
	logic     in_valid;
	logic     in_ready;
	alu_op_t  in_op;
	reg_idx_t in_rd;
	reg_idx_t in_ra;
	reg_idx_t in_rb;
	data_t    in_imm;
	logic     in_use_imm;
	logic     out_valid;
	logic     out_ready;
	reg_idx_t out_rd;
	data_t    out_data;

	// Architectural state and expected results in order
	data_t    arch_regs [REG_CNT];
	data_t    exp_data_q [$];
	reg_idx_t exp_rd_q [$];

	integer   seed = 96;
	logic     stall_mode;
	string    test_name;
	int       errors;
	int       checks;
	int       results;
	int       tests_done;
	int       errors_at_start;
	int       results_at_start;

	int_pipe_top u_int_pipe_top (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_ready   (in_ready),
		.in_op      (in_op),
		.in_rd      (in_rd),
		.in_ra      (in_ra),
		.in_rb      (in_rb),
		.in_imm     (in_imm),
		.in_use_imm (in_use_imm),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.out_rd     (out_rd),
		.out_data   (out_data)
	);

	always #50 clk = ~clk;

	//////////////////////////////
	// Reference model
	//////////////////////////////

	function automatic data_t alu_ref(alu_op_t op, data_t a, data_t b);
		case (op)
			ALU_ADD: return a + b;
			ALU_SUB: return a - b;
			ALU_AND: return a & b;
			ALU_OR:  return a | b;
			ALU_XOR: return a ^ b;
			ALU_SLL: return a << b[SH_W-1:0];
			ALU_SRL: return a >> b[SH_W-1:0];
			default: return ($signed(a) < $signed(b)) ? data_t'(1) : '0;
		endcase
	endfunction

	// Executes one accepted instruction in program order
	function automatic void model_accept(alu_op_t op, reg_idx_t rd, reg_idx_t ra,
		reg_idx_t rb, data_t imm, logic use_imm);
		data_t a;
		data_t b;
		data_t r;
		a = (ra == '0) ? '0 : arch_regs[ra];
		b = use_imm ? imm : ((rb == '0) ? '0 : arch_regs[rb]);
		r = alu_ref(op, a, b);
		if (rd != '0) begin
			arch_regs[rd] = r;
		end
		exp_rd_q.push_back(rd);
		exp_data_q.push_back(r);
	endfunction

	//////////////////////////////
	// Checks
	//////////////////////////////

	task automatic check_data(string what, data_t exp, data_t act);
		checks++;
		if (act !== exp) begin
			$display("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_rd(string what, reg_idx_t exp, reg_idx_t act);
		checks++;
		if (act !== exp) begin
			$display("FAILED %s %s: expected %0d, actual %0d", test_name, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_flag(string what, logic exp, logic act);
		checks++;
		if (act !== exp) begin
			$display("FAILED %s %s: expected %b, actual %b", test_name, what, exp, act);
			errors++;
		end
	endtask

	// Output transfers are compared before new acceptances go to the model
	always @(posedge clk) begin
		if (rst_n) begin
			if (out_valid && out_ready) begin
				results++;
				if (exp_rd_q.size() == 0) begin
					$display("Result with rd %0d came out with nothing expected in %s",
						out_rd, test_name);
					errors++;
				end else begin
					check_rd("out_rd", exp_rd_q.pop_front(), out_rd);
					check_data("out_data", exp_data_q.pop_front(), out_data);
				end
			end
			if (in_valid && in_ready) begin
				model_accept(in_op, in_rd, in_ra, in_rb, in_imm, in_use_imm);
			end
		end
	end

	// Sink side with random stalls when enabled
	always @(negedge clk) begin
		logic [31:0] r;
		if (stall_mode) begin
			r = $random(seed);
			out_ready = (r[1:0] != 2'b00);
		end else begin
			out_ready = 1'b1;
		end
	end

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	task automatic report_timeout(string what);
		$display("Timeout in %s: %s", test_name, what);
		errors++;
	endtask

	task automatic send(alu_op_t op, reg_idx_t rd, reg_idx_t ra, reg_idx_t rb,
		data_t imm, logic use_imm);
		int cycles;
		cycles = 0;
		@(negedge clk);
		in_valid   = 1'b1;
		in_op      = op;
		in_rd      = rd;
		in_ra      = ra;
		in_rb      = rb;
		in_imm     = imm;
		in_use_imm = use_imm;
		@(posedge clk);
		while (!in_ready && cycles < TIMEOUT) begin
			cycles++;
			@(posedge clk);
		end
		if (!in_ready) begin
			report_timeout("instruction never accepted");
		end
	endtask

	task automatic idle(int n);
		repeat (n) begin
			@(negedge clk);
			in_valid = 1'b0;
		end
	endtask

	// Waits until every expected result has left the slice
	task automatic drain();
		int cycles;
		cycles = 0;
		idle(1);
		while ((exp_rd_q.size() != 0 || out_valid) && cycles < TIMEOUT) begin
			cycles++;
			@(negedge clk);
		end
		if (exp_rd_q.size() != 0 || out_valid) begin
			report_timeout("pipeline did not drain");
		end
	endtask

	task automatic begin_test(string name);
		test_name        = name;
		errors_at_start  = errors;
		results_at_start = results;
	endtask

	task automatic end_test();
		tests_done++;
		$display("Test %0d %s done: %0d results, %0d errors", tests_done, test_name,
			results - results_at_start, errors - errors_at_start);
	endtask

	initial begin
		logic [31:0] rnd;
		reg_idx_t    prev;
		reg_idx_t    rd;
		clk        = 1'b0;
		rst_n      = 1'b0;
		in_valid   = 1'b0;
		in_op      = ALU_ADD;
		in_rd      = '0;
		in_ra      = '0;
		in_rb      = '0;
		in_imm     = '0;
		in_use_imm = 1'b0;
		out_ready  = 1'b1;
		stall_mode = 1'b0;
		errors     = 0;
		checks     = 0;
		results    = 0;
		tests_done = 0;
		for (int i = 0; i < REG_CNT; i++) begin
			arch_regs[i] = '0;
		end
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// Seed r1..r7 then run every op on them without hazards
		begin_test("independent");
		for (int i = 1; i < 8; i++) begin
			rnd = $random(seed);
			send(ALU_ADD, reg_idx_t'(i), '0, '0, rnd, 1'b1);
		end
		drain();
		for (int k = 0; k < 8; k++) begin
			rnd = $random(seed);
			send(alu_op_t'(k[2:0]), reg_idx_t'(8 + k), reg_idx_t'(1 + k % 3),
				reg_idx_t'(4 + k % 4), '0, 1'b0);
			send(alu_op_t'(k[2:0]), reg_idx_t'(8 + k), reg_idx_t'(1 + k % 7), '0, rnd, 1'b1);
		end
		drain();
		end_test();

		// Each instruction reads the one just before it
		begin_test("back_to_back");
		prev = 4'd1;
		for (int i = 0; i < 16; i++) begin
			rnd = $random(seed);
			rd  = reg_idx_t'(1 + i % 4);
			send(alu_op_t'(rnd[2:0]), rd, prev, reg_idx_t'(1 + rnd[5:4]), $random(seed), rnd[8]);
			prev = rd;
		end
		drain();
		end_test();

		// Producer, unrelated, consumer
		begin_test("distance_two");
		for (int i = 0; i < 6; i++) begin
			rnd = $random(seed);
			send(alu_op_t'(rnd[2:0]), 4'd5, 4'd1, 4'd2, '0, 1'b0);
			send(ALU_XOR, 4'd6, 4'd7, 4'd3, '0, 1'b0);
			send(alu_op_t'(rnd[6:4]), 4'd8, 4'd5, 4'd5, rnd, rnd[9]);
		end
		// Same destination in WB and EX where the EX copy is newer
		send(ALU_ADD, 4'd3, '0, '0, 32'h0000_1111, 1'b1);
		send(ALU_ADD, 4'd3, '0, '0, 32'h0000_2222, 1'b1);
		send(ALU_ADD, 4'd9, 4'd3, 4'd3, '0, 1'b0);
		send(ALU_OR, 4'd10, 4'd1, 4'd3, '0, 1'b0);
		drain();
		end_test();

		begin_test("register_zero");
		send(ALU_ADD, 4'd0, 4'd1, '0, 32'h1234_5678, 1'b1);
		send(ALU_ADD, 4'd2, 4'd0, 4'd0, '0, 1'b0);
		send(ALU_OR, 4'd3, 4'd0, '0, 32'h0000_00a5, 1'b1);
		send(ALU_SUB, 4'd0, 4'd2, 4'd1, '0, 1'b0);
		send(ALU_ADD, 4'd4, 4'd0, 4'd3, '0, 1'b0);
		drain();
		end_test();

		// Dependent stream with sink stalls and source gaps
		begin_test("backpressure");
		stall_mode = 1'b1;
		prev = 4'd1;
		for (int i = 0; i < 40; i++) begin
			rnd = $random(seed);
			rd  = reg_idx_t'(rnd[1:0]);
			if (rnd[12:11] == 2'b00) begin
				idle(1 + int'(rnd[14:13]));
			end
			send(alu_op_t'(rnd[8:6]), rd, rnd[9] ? prev : reg_idx_t'(rnd[3:2]),
				reg_idx_t'(rnd[5:4]), $random(seed), rnd[10]);
			prev = rd;
		end
		drain();
		stall_mode = 1'b0;
		end_test();

		// Accepted at edge N and visible right after edge N+1
		begin_test("min_latency");
		send(ALU_ADD, 4'd9, 4'd1, '0, 32'h0000_0055, 1'b1);
		idle(1);
		check_flag("out_valid before edge N+1", 1'b0, out_valid);
		@(negedge clk);
		check_flag("out_valid after edge N+1", 1'b1, out_valid);
		drain();
		end_test();

		$display("Tests: %0d, checks: %0d, results: %0d, errors: %0d",
			tests_done, checks, results, errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

// File: src.f
cpu_pkg.sv
fwd_if.sv
pipe_stage.sv
reg_file.sv
decode_ctrl.sv
operand_mux.sv
exec_unit.sv
int_pipe_top.sv
int_pipe_assert.sv
tb_int_pipe.sv

// File: Makefile
# Verilator build and run for the integer execute slice
# Override any variable on the command line, e.g. make TOP=tb_int_pipe

VERILATOR ?= verilator
TOP       ?= tb_int_pipe
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation finished: PASS
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides the result, an aborted run has no pass line
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
